/* dv/tb_cam_track.sv */
`timescale 1ns/1ps

module tb_cam_track;

   logic        clk_camera;
   logic        sys_rst_camera;
   logic [7:0]  cam_data;
   logic        cam_pclk;
   logic        cam_hsync;
   logic        cam_vsync;
   logic        pix_valid;
   logic [8:0]  pix_hcount;
   logic [7:0]  pix_vcount;
   logic [15:0] pix_data;
   logic        mask;
   logic [8:0]  com_x;
   logic [7:0]  com_y;
   logic        com_valid;

   // expected output pixels, packed as {mask, data, vcount, hcount}
   logic [33:0] exp_q[$];
   logic [33:0] exp_pix;
   // oldest expected pixel, taken by the output checker
   logic [33:0] head_pix;
   // expected centroid pulses, packed as {y, x}
   logic [16:0] com_q[$];
   logic [16:0] exp_com;
   // centre of mass the model believes the DUT holds
   logic [8:0]  com_x_m;
   logic [7:0]  com_y_m;
   integer      seed;
   integer      n_err;
   integer      n_pix;
   integer      n_com;
   integer      t;

   cam_track_top u_dut (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data),
      .cam_pclk_i     (cam_pclk),
      .cam_hsync_i    (cam_hsync),
      .cam_vsync_i    (cam_vsync),
      .pix_valid_o    (pix_valid),
      .pix_hcount_o   (pix_hcount),
      .pix_vcount_o   (pix_vcount),
      .pix_data_o     (pix_data),
      .mask_o         (mask),
      .com_x_o        (com_x),
      .com_y_o        (com_y),
      .com_valid_o    (com_valid)
   );

   initial begin
      clk_camera = 1'b0;
      forever #4 clk_camera = ~clk_camera;
   end

   task automatic idle(input int n);
      repeat (n) @(negedge clk_camera);
   endtask

   // Cr = 128 + (112 R - 94 G - 18 B) >> 8 on 8-bit expanded fields
   function automatic logic in_window(input cam_track_pkg::pixel_u p);
      int r8;
      int g8;
      int b8;
      int s;
      int cr;
      r8 = {p.rgb.red, 3'b000};
      g8 = {p.rgb.green, 2'b00};
      b8 = {p.rgb.blue, 3'b000};
      s  = 112 * r8 - 94 * g8 - 18 * b8;
      cr = (128 + (s >>> 8)) & 255;
      return (cr >= 'hA0) && (cr <= 'hF0);
   endfunction

   // one byte per pclk period, each level held 3 cycles
   task automatic send_byte(input logic [7:0] b);
      cam_data = b;
      cam_pclk = 1'b0;
      idle(3);
      cam_pclk = 1'b1;
      idle(3);
   endtask

   // mode 0 random with a pink patch, mode 1 red off so nothing marks
   task automatic send_frame(input int mode);
      cam_track_pkg::pixel_u p;
      logic m;
      int x0;
      int y0;
      longint sx;
      longint sy;
      longint n;
      sx = 0;
      sy = 0;
      n  = 0;
      x0 = $random(seed) & 255;
      y0 = $random(seed) & 127;
      cam_vsync = 1'b1;
      idle(6);
      cam_vsync = 1'b0;
      idle(6);
      for (int v = 0; v < cam_track_pkg::V_ACTIVE; v++) begin
         cam_hsync = 1'b1;
         for (int h = 0; h < cam_track_pkg::H_ACTIVE; h++) begin
            p.raw = $random(seed);
            if (mode == 1) begin
               p.rgb.red = 5'd0;
            end else if (h >= x0 && h < x0 + 32 && v >= y0 && v < y0 + 24) begin
               // strong red, weak green and blue
               p.rgb.red   = {2'b11, p.rgb.red[2:0]};
               p.rgb.green = {3'b000, p.rgb.green[2:0]};
               p.rgb.blue  = {2'b00, p.rgb.blue[2:0]};
            end
            m = in_window(p);
            if (m) begin
               sx += h;
               sy += v;
               n++;
            end
            exp_pix[8:0]   = h;
            exp_pix[16:9]  = v;
            exp_pix[32:17] = (h == com_x_m || v == com_y_m) ?
                             cam_track_pkg::WHITE_PIXEL : p.raw;
            exp_pix[33]    = m;
            exp_q.push_back(exp_pix);
            send_byte(p.raw[15:8]);
            send_byte(p.raw[7:0]);
         end
         // stray byte on line 0, hsync fall must drop it
         if (v == 0)
            send_byte(8'h5A);
         cam_pclk  = 1'b0;
         cam_hsync = 1'b0;
         idle(6);
      end
      // floor centroid, only for frames with marks
      if (n != 0) begin
         com_x_m = sx / n;
         com_y_m = sy / n;
         com_q.push_back({com_y_m, com_x_m});
      end
      t = 0;
      while (com_q.size() != 0 && t < 200) begin
         idle(1);
         t++;
      end
      if (com_q.size() != 0) begin
         n_err++;
         $display("centroid pulse did not arrive after the frame");
         com_q.delete();
      end
      idle(100);
      if (com_x !== com_x_m || com_y !== com_y_m) begin
         n_err++;
         $display("Error: com_x_o/com_y_o got %h/%h expected %h/%h", com_x, com_y,
                  com_x_m, com_y_m);
      end
   endtask

   // output checkers, sampled away from the active edge
   always @(negedge clk_camera) begin
      if (pix_valid) begin
         n_pix++;
         if (exp_q.size() == 0) begin
            n_err++;
            $display("output pixel appeared with none outstanding");
         end else begin
            head_pix = exp_q.pop_front();
            if (pix_hcount !== head_pix[8:0]) begin
               n_err++;
               $display("Error: pix_hcount_o got %h expected %h", pix_hcount, head_pix[8:0]);
            end
            if (pix_vcount !== head_pix[16:9]) begin
               n_err++;
               $display("Error: pix_vcount_o got %h expected %h", pix_vcount, head_pix[16:9]);
            end
            if (pix_data !== head_pix[32:17]) begin
               n_err++;
               $display("Error: pix_data_o got %h expected %h", pix_data, head_pix[32:17]);
            end
            if (mask !== head_pix[33]) begin
               n_err++;
               $display("Error: mask_o got %h expected %h", mask, head_pix[33]);
            end
         end
      end
      if (com_valid) begin
         n_com++;
         if (com_q.size() == 0) begin
            n_err++;
            $display("centroid pulse appeared with none expected");
         end else begin
            exp_com = com_q.pop_front();
            if (com_x !== exp_com[8:0] || com_y !== exp_com[16:9]) begin
               n_err++;
               $display("Error: com_x_o/com_y_o got %h/%h expected %h/%h", com_x, com_y,
                        exp_com[8:0], exp_com[16:9]);
            end
         end
      end
   end

   initial begin
      seed           = 13898;
      n_err          = 0;
      n_pix          = 0;
      n_com          = 0;
      com_x_m        = '0;
      com_y_m        = '0;
      sys_rst_camera = 1'b1;
      cam_data       = 8'h00;
      cam_pclk       = 1'b0;
      cam_hsync      = 1'b0;
      cam_vsync      = 1'b0;
      idle(2);
      sys_rst_camera = 1'b0;
      // quiet camera, outputs must stay idle
      for (int i = 0; i < 40; i++) begin
         idle(1);
         if (pix_valid !== 1'b0 || com_valid !== 1'b0 || com_x !== '0 || com_y !== '0) begin
            n_err++;
            $display("outputs active after reset with an idle camera");
         end
      end
      send_frame(0);
      send_frame(1);
      send_frame(0);
      t = 0;
      while (exp_q.size() != 0 && t < 100) begin
         idle(1);
         t++;
      end
      if (exp_q.size() != 0) begin
         n_err++;
         $display("%0d pixels never came out", exp_q.size());
      end
      $display("errors %0d, pixels %0d, centroid pulses %0d", n_err, n_pix, n_com);
      if (n_err == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* hw/cam_capture.sv */
`timescale 1ns/1ps

module cam_capture (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [7:0]  cam_data_i,
   input  logic        cam_pclk_i,
   input  logic        cam_hsync_i,
   input  logic        cam_vsync_i,
   pixel_stream_if.src pix
);

   // two-flop synchronizers, all pins share the same delay
   logic [7:0] data_s0, data_s1;
   logic       pclk_s0, pclk_s1;
   logic       hsync_s0, hsync_s1;
   logic       vsync_s0, vsync_s1;

   // edge detect flops
   logic pclk_q;
   logic hsync_q;
   logic pclk_rise;
   logic hsync_fall;

   // byte pairing and position of the next pixel
   logic                   phase;
   logic [7:0]             hi_byte;
   cam_track_pkg::hcount_t h_next;
   cam_track_pkg::vcount_t v_next;

   // synchronizers and edge history
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_s0  <= '0;
         data_s1  <= '0;
         pclk_s0  <= 1'b0;
         pclk_s1  <= 1'b0;
         hsync_s0 <= 1'b0;
         hsync_s1 <= 1'b0;
         vsync_s0 <= 1'b0;
         vsync_s1 <= 1'b0;
         pclk_q   <= 1'b0;
         hsync_q  <= 1'b0;
      end else begin
         data_s0  <= cam_data_i;
         data_s1  <= data_s0;
         pclk_s0  <= cam_pclk_i;
         pclk_s1  <= pclk_s0;
         hsync_s0 <= cam_hsync_i;
         hsync_s1 <= hsync_s0;
         vsync_s0 <= cam_vsync_i;
         vsync_s1 <= vsync_s0;
         pclk_q   <= pclk_s1;
         hsync_q  <= hsync_s1;
      end
   end

   assign pclk_rise  = pclk_s1 && !pclk_q;
   assign hsync_fall = !hsync_s1 && hsync_q;

   // byte pairing, counters and output register
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         phase      <= 1'b0;
         hi_byte    <= '0;
         h_next     <= '0;
         v_next     <= '0;
         pix.valid  <= 1'b0;
         pix.hcount <= '0;
         pix.vcount <= '0;
         pix.pixel  <= '0;
      end else begin
         pix.valid <= 1'b0;
         if (vsync_s1) begin
            // new frame
            phase  <= 1'b0;
            v_next <= '0;
         end else if (hsync_fall) begin
            // line done, a lone high byte is dropped
            phase  <= 1'b0;
            h_next <= '0;
            v_next <= v_next + 1'b1;
         end else if (pclk_rise && hsync_s1) begin
            if (!phase) begin
               hi_byte <= data_s1;
               phase   <= 1'b1;
            end else begin
               // low byte completes the pixel
               phase         <= 1'b0;
               pix.valid     <= 1'b1;
               pix.hcount    <= h_next;
               pix.vcount    <= v_next;
               pix.pixel.raw <= {hi_byte, data_s1};
               h_next        <= h_next + 1'b1;
            end
         end
      end
   end

   // pixels are at least a pclk period apart
   a_valid_single : assert property (@(posedge clk_i) disable iff (rst_i)
      pix.valid |=> !pix.valid)
      else $error("capture valid high on two consecutive cycles");

   // line never longer than the active width
   a_hcount_range : assert property (@(posedge clk_i) disable iff (rst_i)
      pix.valid |-> (pix.hcount < cam_track_pkg::H_ACTIVE))
      else $error("capture hcount %0d beyond active line", pix.hcount);

endmodule

/* hw/cam_track_pkg.sv */
package cam_track_pkg;

   // active camera frame, 320x180 after the sensor's own scaling
   localparam int H_ACTIVE = 320;
   localparam int V_ACTIVE = 180;

   // count widths, enough for 0..319 and 0..179
   localparam int HCOUNT_W = 9;
   localparam int VCOUNT_W = 8;

   typedef logic [HCOUNT_W-1:0] hcount_t;
   typedef logic [VCOUNT_W-1:0] vcount_t;

   // rgb565 field view of a pixel word
   typedef struct packed {
      logic [4:0] red;
      logic [5:0] green;
      logic [4:0] blue;
   } rgb565_t;

   // one 16-bit pixel word, seen raw or split into colour fields
   typedef union packed {
      logic [15:0] raw;
      rgb565_t     rgb;
   } pixel_u;

   // centroid sums, sized for a fully marked frame
   // sum of all hcounts over a frame is about 9.2M
   localparam int SUM_X_W = 24;
   // sum of all vcounts over a frame is about 5.2M
   localparam int SUM_Y_W = 23;
   // marked pixel count, at most 57600
   localparam int NPIX_W = 16;

   // crosshair colour
   localparam logic [15:0] WHITE_PIXEL = 16'hFFFF;

endpackage

/* hw/cam_track_top.sv */
`timescale 1ns/1ps

module cam_track_top #(
   // Cr window for the pink marker
   parameter logic [7:0] CR_LOW  = 8'hA0,
   parameter logic [7:0] CR_HIGH = 8'hF0
) (
   input  logic                   clk_camera,
   input  logic                   sys_rst_camera,
   // camera parallel bus
   input  logic [7:0]             cam_data_i,
   input  logic                   cam_pclk_i,
   input  logic                   cam_hsync_i,
   input  logic                   cam_vsync_i,
   // outgoing pixel stream with crosshair
   output logic                   pix_valid_o,
   output cam_track_pkg::hcount_t pix_hcount_o,
   output cam_track_pkg::vcount_t pix_vcount_o,
   output logic [15:0]            pix_data_o,
   output logic                   mask_o,
   // centre of mass, held between frames
   output cam_track_pkg::hcount_t com_x_o,
   output cam_track_pkg::vcount_t com_y_o,
   output logic                   com_valid_o
);

   // capture to chroma
   pixel_stream_if u_pix_if ();
   // chroma to centroid and overlay
   mask_stream_if  u_mask_if ();

   cam_capture u_capture (
      .clk_i       (clk_camera),
      .rst_i       (sys_rst_camera),
      .cam_data_i  (cam_data_i),
      .cam_pclk_i  (cam_pclk_i),
      .cam_hsync_i (cam_hsync_i),
      .cam_vsync_i (cam_vsync_i),
      .pix         (u_pix_if.src)
   );

   chroma_mask #(
      .CR_LOW  (CR_LOW),
      .CR_HIGH (CR_HIGH)
   ) u_chroma (
      .clk_i (clk_camera),
      .rst_i (sys_rst_camera),
      .pix   (u_pix_if.snk),
      .mpix  (u_mask_if.src)
   );

   centroid_track u_centroid (
      .clk_i       (clk_camera),
      .rst_i       (sys_rst_camera),
      .mpix        (u_mask_if.snk),
      .com_x_o     (com_x_o),
      .com_y_o     (com_y_o),
      .com_valid_o (com_valid_o)
   );

   // crosshair follows the last finished frame
   crosshair_overlay u_overlay (
      .clk_i        (clk_camera),
      .rst_i        (sys_rst_camera),
      .mpix         (u_mask_if.snk),
      .com_x_i      (com_x_o),
      .com_y_i      (com_y_o),
      .pix_valid_o  (pix_valid_o),
      .pix_hcount_o (pix_hcount_o),
      .pix_vcount_o (pix_vcount_o),
      .pix_data_o   (pix_data_o),
      .mask_o       (mask_o)
   );

endmodule

/* hw/centroid_track.sv */
`timescale 1ns/1ps

module centroid_track (
   input  logic                   clk_i,
   input  logic                   rst_i,
   mask_stream_if.snk             mpix,
   output cam_track_pkg::hcount_t com_x_o,
   output cam_track_pkg::vcount_t com_y_o,
   output logic                   com_valid_o
);

   localparam int HW    = cam_track_pkg::HCOUNT_W;
   localparam int VW    = cam_track_pkg::VCOUNT_W;
   localparam int SX_W  = cam_track_pkg::SUM_X_W;
   localparam int SY_W  = cam_track_pkg::SUM_Y_W;
   localparam int N_W   = cam_track_pkg::NPIX_W;
   // remainder plus one guard bit, then the dividend and quotient
   localparam int ACC_W = N_W + 1 + SX_W;
   localparam int CNT_W = $clog2(SX_W);
   localparam cam_track_pkg::hcount_t LAST_H =
      cam_track_pkg::hcount_t'(cam_track_pkg::H_ACTIVE - 1);
   localparam cam_track_pkg::vcount_t LAST_V =
      cam_track_pkg::vcount_t'(cam_track_pkg::V_ACTIVE - 1);

   // one restoring division step on {remainder, dividend/quotient}
   function automatic logic [ACC_W-1:0] div_step(input logic [ACC_W-1:0] acc,
                                                 input logic [N_W-1:0]   dvs);
      logic [ACC_W-1:0] sh;
      logic [N_W:0]     rem;
      sh  = acc << 1;
      rem = sh[ACC_W-1 -: N_W+1];
      // subtract only when it fits, quotient bit enters at the bottom
      if (rem >= {1'b0, dvs}) begin
         sh[ACC_W-1 -: N_W+1] = rem - {1'b0, dvs};
         sh[0]                = 1'b1;
      end
      return sh;
   endfunction

   logic             hit;
   logic             last_pix;
   logic [SX_W-1:0]  sum_x, x_add, sum_x_tot;
   logic [SY_W-1:0]  sum_y, y_add, sum_y_tot;
   logic [N_W-1:0]   npix, npix_tot;
   logic             busy;
   logic [CNT_W-1:0] step_cnt;
   logic [ACC_W-1:0] acc_x, acc_y;
   logic [ACC_W-1:0] acc_x_nxt, acc_y_nxt;
   logic [N_W-1:0]   divisor;

   assign hit      = mpix.valid && mpix.mask;
   assign last_pix = mpix.valid && (mpix.hcount == LAST_H) && (mpix.vcount == LAST_V);

   // running totals including the pixel on the bus
   assign x_add     = hit ? {{(SX_W - HW){1'b0}}, mpix.hcount} : '0;
   assign y_add     = hit ? {{(SY_W - VW){1'b0}}, mpix.vcount} : '0;
   assign sum_x_tot = sum_x + x_add;
   assign sum_y_tot = sum_y + y_add;
   assign npix_tot  = npix + N_W'(hit);

   // both dividers share the divisor, y dividend is zero-extended
   assign acc_x_nxt = div_step(acc_x, divisor);
   assign acc_y_nxt = div_step(acc_y, divisor);

   // per-frame accumulators, emptied at the last pixel
   always_ff @(posedge clk_i) begin
      if (rst_i || last_pix) begin
         sum_x <= '0;
         sum_y <= '0;
         npix  <= '0;
      end else begin
         sum_x <= sum_x_tot;
         sum_y <= sum_y_tot;
         npix  <= npix_tot;
      end
   end

   // divider sequencing and held result
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy        <= 1'b0;
         step_cnt    <= '0;
         com_valid_o <= 1'b0;
         com_x_o     <= '0;
         com_y_o     <= '0;
      end else begin
         com_valid_o <= 1'b0;
         if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            // final step, quotient goes straight into the held outputs
            if (step_cnt == CNT_W'(SX_W - 1)) begin
               busy        <= 1'b0;
               com_valid_o <= 1'b1;
               com_x_o     <= acc_x_nxt[HW-1:0];
               com_y_o     <= acc_y_nxt[VW-1:0];
            end
         end else if (last_pix && (npix_tot != '0)) begin
            // empty frame never starts, old centre stays
            busy     <= 1'b1;
            step_cnt <= '0;
         end
      end
   end

   // divider datapath
   always_ff @(posedge clk_i) begin
      if (busy) begin
         acc_x <= acc_x_nxt;
         acc_y <= acc_y_nxt;
      end else if (last_pix) begin
         acc_x   <= {{(ACC_W - SX_W){1'b0}}, sum_x_tot};
         acc_y   <= {{(ACC_W - SY_W){1'b0}}, sum_y_tot};
         divisor <= npix_tot;
      end
   end

   // frame gap must cover the divide
   a_no_overlap : assert property (@(posedge clk_i) disable iff (rst_i) busy |-> !last_pix)
      else $error("frame ended while centroid divide still running");

endmodule

/* hw/chroma_mask.sv */
`timescale 1ns/1ps

module chroma_mask #(
   parameter logic [7:0] CR_LOW  = 8'hA0,
   parameter logic [7:0] CR_HIGH = 8'hF0
) (
   input  logic        clk_i,
   input  logic        rst_i,
   pixel_stream_if.snk pix,
   mask_stream_if.src  mpix
);

   // colour fields widened to 8 bits, low bits zero
   logic [7:0] r8, g8, b8;

   // stage 1 registers
   logic                   s1_valid;
   cam_track_pkg::hcount_t s1_hcount;
   cam_track_pkg::vcount_t s1_vcount;
   cam_track_pkg::pixel_u  s1_pixel;
   // scaled Cr before the offset, fits easily in 17 bits signed
   logic signed [16:0]     s1_sum;

   // stage 2 combinational Cr
   logic signed [16:0] cr_full;
   logic [7:0]         cr;

   assign r8 = {pix.pixel.rgb.red, 3'b000};
   assign g8 = {pix.pixel.rgb.green, 2'b00};
   assign b8 = {pix.pixel.rgb.blue, 3'b000};

   // Cr = 128 + (112 R - 94 G - 18 B) >> 8
   assign cr_full = 17'sd128 + (s1_sum >>> 8);
   assign cr      = cr_full[7:0];

   // stage 1, multiply and sum
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= pix.valid;
      end
      s1_hcount <= pix.hcount;
      s1_vcount <= pix.vcount;
      s1_pixel  <= pix.pixel;
      s1_sum    <= 17'sd112 * $signed({9'b0, r8})
                 - 17'sd94 * $signed({9'b0, g8})
                 - 17'sd18 * $signed({9'b0, b8});
   end

   // stage 2, window test, counts and pixel ride along
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mpix.valid <= 1'b0;
      end else begin
         mpix.valid <= s1_valid;
      end
      mpix.hcount <= s1_hcount;
      mpix.vcount <= s1_vcount;
      mpix.pixel  <= s1_pixel;
      // inclusive at both ends
      mpix.mask   <= (cr >= CR_LOW) && (cr <= CR_HIGH);
   end

   // window must not be empty
   a_window_order : assert property (@(posedge clk_i) CR_LOW <= CR_HIGH)
      else $error("chroma window inverted, low %h high %h", CR_LOW, CR_HIGH);

endmodule

/* hw/crosshair_overlay.sv */
`timescale 1ns/1ps

module crosshair_overlay (
   input  logic                   clk_i,
   input  logic                   rst_i,
   mask_stream_if.snk             mpix,
   input  cam_track_pkg::hcount_t com_x_i,
   input  cam_track_pkg::vcount_t com_y_i,
   output logic                   pix_valid_o,
   output cam_track_pkg::hcount_t pix_hcount_o,
   output cam_track_pkg::vcount_t pix_vcount_o,
   output logic [15:0]            pix_data_o,
   output logic                   mask_o
);

   // pixel sits on the crosshair row or column
   logic on_cross;

   assign on_cross = (mpix.hcount == com_x_i) || (mpix.vcount == com_y_i);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pix_valid_o  <= 1'b0;
         pix_hcount_o <= '0;
         pix_vcount_o <= '0;
      end else begin
         pix_valid_o  <= mpix.valid;
         pix_hcount_o <= mpix.hcount;
         pix_vcount_o <= mpix.vcount;
      end
      // white lines over the raw camera pixel
      pix_data_o <= on_cross ? cam_track_pkg::WHITE_PIXEL : mpix.pixel.raw;
      // mask unchanged
      mask_o     <= mpix.mask;
   end

endmodule

/* hw/pixel_stream_if.sv */
`timescale 1ns/1ps

// pixel stream from capture into the chroma stage
// valid is a one-cycle strobe, other fields only meaningful with it
interface pixel_stream_if ();
   logic                   valid;
   cam_track_pkg::hcount_t hcount;
   cam_track_pkg::vcount_t vcount;
   cam_track_pkg::pixel_u  pixel;

   // producer side
   modport src (output valid, hcount, vcount, pixel);
   // consumer side
   modport snk (input valid, hcount, vcount, pixel);
endinterface

// pixel stream with its chroma mask bit
// one producer, read by both centroid and overlay
interface mask_stream_if ();
   logic                   valid;
   cam_track_pkg::hcount_t hcount;
   cam_track_pkg::vcount_t vcount;
   cam_track_pkg::pixel_u  pixel;
   // pixel falls inside the Cr window
   logic                   mask;

   // producer side
   modport src (output valid, hcount, vcount, pixel, mask);
   // consumer side, fans out to several readers
   modport snk (input valid, hcount, vcount, pixel, mask);
endinterface

/* tb.f */
hw/cam_track_pkg.sv
hw/pixel_stream_if.sv
hw/cam_capture.sv
hw/chroma_mask.sv
hw/centroid_track.sv
hw/crosshair_overlay.sv
hw/cam_track_top.sv
dv/tb_cam_track.sv
